// File: filelist.f
logic/lsu_pkg.sv
logic/axi_lite_if.sv
logic/lsu_load_unit.sv
logic/lsu_store_unit.sv
logic/lsu_request_ctrl.sv
logic/axi_lite_sram.sv
logic/lsu_subsystem.sv
verif/lsu_tb.sv

// File: Makefile
# Verilator build and run of the LSU testbench.

VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= build
BIN       ?= sim
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(BIN)
	./$(BUILD_DIR)/$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulation exited with status $$status"; exit 1; fi
	@if grep -q "Test FAILED" $(LOG); then \
		echo "failure found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

	localparam logic [31:0] seed = 32'he4de_2f18;
	localparam int win_words    = 64;
	localparam int req_timeout  = 50;
	localparam int resp_timeout = 400;

	logic              clock = 1'b0;
	logic              rst_n;
	logic              req_valid;
	logic              req_ready;
	mem_op_e           req_op;
	logic [data_w-1:0] req_base;
	logic [data_w-1:0] req_imm;
	logic [data_w-1:0] req_wdata;
	logic              resp_valid;
	logic              resp_ready;
	logic [data_w-1:0] resp_data;
	resp_e             resp_status;

	logic [31:0] lfsr = seed;
	logic [31:0] shadow [mem_words];
	int          errors = 0;
	int          checks = 0;
	int          hold_errors = 0;
	int          prop_errors = 0;
	logic        stalled = 1'b0;
	logic        heavy = 1'b0;
	logic        hold_seen = 1'b0;
	logic [31:0] hold_data;
	resp_e       hold_status;

	mem_op_e all_ops [8] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};
	mem_op_e narrow_ops [8] = '{op_lb, op_lh, op_lbu, op_lhu, op_sb, op_sh, op_lb, op_sh};
	mem_op_e wide_ops [8] = '{op_lh, op_lhu, op_sh, op_lw, op_sw, op_lh, op_sw, op_lw};

	lsu_subsystem u_dut (
		.clock       (clock),
		.rst_n       (rst_n),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_op      (req_op),
		.req_base    (req_base),
		.req_imm     (req_imm),
		.req_wdata   (req_wdata),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_data   (resp_data),
		.resp_status (resp_status)
	);

	always #10 clock = ~clock;

	// taps 32, 22, 2, 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic pick_ready();
		if (heavy) begin
			return rand_bits(3) == 0;
		end
		return rand_bits(2) != 0;
	endfunction

	// predicts the response from the access rules and updates the shadow copy on stores.
	task automatic predict(input mem_op_e op, input logic [31:0] addr, input logic [31:0] wdata,
			output logic [31:0] exp_data, output resp_e exp_status);
		int          size;
		logic        is_load;
		logic        sign_ext;
		logic [1:0]  off;
		logic [9:0]  idx;
		logic [31:0] lane;
		case (op)
			op_lb, op_lbu, op_sb: size = 1;
			op_lh, op_lhu, op_sh: size = 2;
			default:              size = 4;
		endcase
		is_load  = op inside {op_lb, op_lh, op_lw, op_lbu, op_lhu};
		sign_ext = op inside {op_lb, op_lh};
		off      = addr[1:0];
		idx      = addr[11:2];
		exp_data = '0;
		if ((size == 2 && off[0]) || (size == 4 && off != 2'd0)) begin
			exp_status = resp_misaligned;
		end else if (addr[31:12] != 20'h0) begin
			exp_status = resp_bus_error;
		end else begin
			exp_status = resp_okay;
			if (is_load) begin
				lane = shadow[idx] >> (8 * off);
				if (size == 1) begin
					exp_data = sign_ext ? {{24{lane[7]}}, lane[7:0]} : {24'h0, lane[7:0]};
				end else if (size == 2) begin
					exp_data = sign_ext ? {{16{lane[15]}}, lane[15:0]} : {16'h0, lane[15:0]};
				end else begin
					exp_data = lane;
				end
			end else begin
				for (int b = 0; b < size; b++) begin
					shadow[idx][(off + b) * 8 +: 8] = wdata[b * 8 +: 8];
				end
			end
		end
	endtask

	task automatic check_value(input string name, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("error: %s %s expected %h actual %h", name, what, exp, act);
		end
	endtask

	task automatic report_stall(input string name, input string what);
		errors++;
		stalled = 1'b1;
		$display("stall: %s access gave no %s within the wait limit", name, what);
	endtask

	task automatic access(input string name, input mem_op_e op, input logic [31:0] addr);
		logic [31:0] base;
		logic [31:0] wdata;
		logic [31:0] exp_data;
		resp_e       exp_status;
		int          waited;
		logic        got;
		if (stalled) begin
			return;
		end
		base  = rand_bits(32);
		wdata = rand_bits(32);
		predict(op, addr, wdata, exp_data, exp_status);
		@(posedge clock);
		req_valid <= 1'b1;
		req_op    <= op;
		req_base  <= base;
		req_imm   <= addr - base;
		req_wdata <= wdata;
		waited = 0;
		@(negedge clock);
		while (!req_ready && !stalled) begin
			waited++;
			if (waited > req_timeout) begin
				report_stall(name, "req_ready");
			end else begin
				@(negedge clock);
			end
		end
		if (stalled) begin
			return;
		end
		@(posedge clock);
		req_valid <= 1'b0;
		got    = 1'b0;
		waited = 0;
		while (!got && !stalled) begin
			@(posedge clock);
			resp_ready <= pick_ready();
			@(negedge clock);
			if (resp_valid && resp_ready) begin
				got = 1'b1;
			end else begin
				waited++;
				if (waited > resp_timeout) begin
					report_stall(name, "response");
				end
			end
		end
		if (stalled) begin
			return;
		end
		check_value(name, "resp_data", exp_data, resp_data);
		check_value(name, "resp_status", 32'(exp_status), 32'(resp_status));
		@(posedge clock);
		resp_ready <= 1'b0;
	endtask

	// a stalled response must not move.
	always @(negedge clock) begin
		if (hold_seen) begin
			assert (resp_data === hold_data) else begin
				hold_errors = hold_errors + 1;
				$display("error: backpressure resp_data expected %h actual %h",
					hold_data, resp_data);
			end
			assert (resp_status === hold_status) else begin
				hold_errors = hold_errors + 1;
				$display("error: backpressure resp_status expected %h actual %h",
					hold_status, resp_status);
			end
		end
		hold_seen   <= rst_n && resp_valid && !resp_ready;
		hold_data   <= resp_data;
		hold_status <= resp_status;
	end

	resp_held: assert property (@(posedge clock) disable iff (!rst_n)
			resp_valid && !resp_ready |=> resp_valid)
		else begin
			prop_errors = prop_errors + 1;
			$display("error: resp_valid dropped while the response was stalled");
		end

	no_accept: assert property (@(posedge clock) disable iff (!rst_n)
			resp_valid |-> !req_ready)
		else begin
			prop_errors = prop_errors + 1;
			$display("error: req_ready was high while a response was pending");
		end

	initial begin
		logic [5:0]  word;
		logic [1:0]  off;
		logic [19:0] hi;
		mem_op_e     op;
		int          total;
		rst_n      = 1'b0;
		req_valid  = 1'b0;
		req_op     = op_lw;
		req_base   = '0;
		req_imm    = '0;
		req_wdata  = '0;
		resp_ready = 1'b0;
		repeat (2) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		check_value("reset", "resp_valid", 32'h0, 32'(resp_valid));
		check_value("reset", "req_ready", 32'h1, 32'(req_ready));

		// fill the window so that no load sees an unwritten word.
		for (int i = 0; i < win_words; i++) begin
			access("fill", op_sw, 32'(i * 4));
		end
		for (int i = 0; i < 40; i++) begin
			word = 6'(rand_bits(6));
			access("round_trip", op_sw, {24'h0, word, 2'b00});
			access("round_trip", op_lw, {24'h0, word, 2'b00});
		end
		for (int i = 0; i < 100; i++) begin
			op   = narrow_ops[3'(rand_bits(3))];
			word = 6'(rand_bits(6));
			off  = 2'(rand_bits(2));
			if (op inside {op_lh, op_lhu, op_sh}) begin
				off[0] = 1'b0;
			end
			access("narrow", op, {24'h0, word, off});
		end
		for (int i = 0; i < 30; i++) begin
			op   = wide_ops[3'(rand_bits(3))];
			word = 6'(rand_bits(6));
			off  = 2'(rand_bits(2));
			if (op inside {op_lh, op_lhu, op_sh}) begin
				off[0] = 1'b1;
			end else if (off == 2'd0) begin
				off = 2'd2;
			end
			access("misaligned", op, {24'h0, word, off});
			access("misaligned", op_lw, {24'h0, word, 2'b00});
		end
		// low bits land inside the window to catch aliasing.
		for (int i = 0; i < 30; i++) begin
			hi   = 20'(rand_bits(20));
			word = 6'(rand_bits(6));
			if (hi == 20'h0) begin
				hi = 20'h1;
			end
			op = rand_bits(1) != 0 ? op_sw : op_lw;
			access("range", op, {hi, 4'h0, word, 2'b00});
			access("range", op_lw, {24'h0, word, 2'b00});
		end
		heavy = 1'b1;
		for (int i = 0; i < 40; i++) begin
			op   = all_ops[3'(rand_bits(3))];
			word = 6'(rand_bits(6));
			off  = 2'(rand_bits(2));
			access("backpressure", op, {24'h0, word, off});
		end
		heavy = 1'b0;

		total = errors + hold_errors + prop_errors;
		$display("checks %0d, errors %0d (response %0d, backpressure %0d, protocol %0d)",
			checks, total, errors, hold_errors, prop_errors);
		if (total == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: logic/lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem import lsu_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              req_valid,
	output logic              req_ready,
	input  mem_op_e           req_op,
	input  logic [data_w-1:0] req_base,
	input  logic [data_w-1:0] req_imm,
	input  logic [data_w-1:0] req_wdata,
	output logic              resp_valid,
	input  logic              resp_ready,
	output logic [data_w-1:0] resp_data,
	output resp_e             resp_status
);

	logic              ld_start;
	logic              st_start;
	logic              ld_done;
	logic              st_done;
	logic [addr_w-1:0] acc_addr;
	mem_op_e           acc_op;
	logic [data_w-1:0] acc_wdata;
	logic [data_w-1:0] ld_data;
	axi_resp_e         ld_resp;
	axi_resp_e         st_resp;

	axi_lite_if rd_bus (.clock(clock));
	axi_lite_if wr_bus (.clock(clock));

	lsu_request_ctrl u_request (
		.clock       (clock),
		.rst_n       (rst_n),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_op      (req_op),
		.req_base    (req_base),
		.req_imm     (req_imm),
		.req_wdata   (req_wdata),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_data   (resp_data),
		.resp_status (resp_status),
		.ld_start    (ld_start),
		.st_start    (st_start),
		.acc_addr    (acc_addr),
		.acc_op      (acc_op),
		.acc_wdata   (acc_wdata),
		.ld_done     (ld_done),
		.st_done     (st_done),
		.ld_data     (ld_data),
		.ld_resp     (ld_resp),
		.st_resp     (st_resp)
	);

	lsu_load_unit u_load (
		.clock (clock),
		.rst_n (rst_n),
		.start (ld_start),
		.addr  (acc_addr),
		.op    (acc_op),
		.done  (ld_done),
		.data  (ld_data),
		.resp  (ld_resp),
		.bus   (rd_bus.master)
	);

	lsu_store_unit u_store (
		.clock (clock),
		.rst_n (rst_n),
		.start (st_start),
		.addr  (acc_addr),
		.op    (acc_op),
		.wdata (acc_wdata),
		.done  (st_done),
		.resp  (st_resp),
		.bus   (wr_bus.master)
	);

	axi_lite_sram u_sram (
		.clock (clock),
		.rst_n (rst_n),
		.rd    (rd_bus.slave),
		.wr    (wr_bus.slave)
	);

endmodule

// File: logic/axi_lite_sram.sv
`timescale 1ns/1ps

module axi_lite_sram import lsu_pkg::*; (
	input  logic      clock,
	input  logic      rst_n,
	axi_lite_if.slave rd,
	axi_lite_if.slave wr
);

	logic [data_w-1:0] mem [mem_words];

	logic              aw_done;
	logic              w_done;
	logic [addr_w-1:0] aw_addr_q;
	logic [data_w-1:0] w_data_q;
	logic [strb_w-1:0] w_strb_q;
	logic              rd_in_range;
	logic              wr_in_range;
	logic [mem_idx_w-1:0] rd_idx;
	logic [mem_idx_w-1:0] wr_idx;

	// anything above the 4 KiB window is an error.
	assign rd_in_range = ~|rd.ar_addr[addr_w-1:mem_idx_w+off_w];
	assign wr_in_range = ~|aw_addr_q[addr_w-1:mem_idx_w+off_w];
	assign rd_idx      = rd.ar_addr[mem_idx_w+off_w-1:off_w];
	assign wr_idx      = aw_addr_q[mem_idx_w+off_w-1:off_w];

	assign rd.ar_ready = !rd.r_valid;
	assign wr.aw_ready = !aw_done && !wr.b_valid;
	assign wr.w_ready  = !w_done && !wr.b_valid;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rd.r_valid <= 1'b0;
		end else if (rd.ar_valid && rd.ar_ready) begin
			rd.r_valid <= 1'b1;
		end else if (rd.r_ready) begin
			rd.r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (rd.ar_valid && rd.ar_ready) begin
			rd.r_data <= rd_in_range ? mem[rd_idx] : '0;
			rd.r_resp <= rd_in_range ? axi_okay : axi_slverr;
		end
	end

	// write fires once both address and data are in, whichever came first.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			aw_done    <= 1'b0;
			w_done     <= 1'b0;
			wr.b_valid <= 1'b0;
		end else begin
			if (aw_done && w_done) begin
				aw_done    <= 1'b0;
				w_done     <= 1'b0;
				wr.b_valid <= 1'b1;
			end else begin
				if (wr.aw_valid && wr.aw_ready) begin
					aw_done <= 1'b1;
				end
				if (wr.w_valid && wr.w_ready) begin
					w_done <= 1'b1;
				end
				if (wr.b_ready) begin
					wr.b_valid <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (wr.aw_valid && wr.aw_ready) begin
			aw_addr_q <= wr.aw_addr;
		end
		if (wr.w_valid && wr.w_ready) begin
			w_data_q <= wr.w_data;
			w_strb_q <= wr.w_strb;
		end
		if (aw_done && w_done) begin
			wr.b_resp <= wr_in_range ? axi_okay : axi_slverr;
			if (wr_in_range) begin
				for (int i = 0; i < strb_w; i++) begin
					if (w_strb_q[i]) begin
						mem[wr_idx][i*8 +: 8] <= w_data_q[i*8 +: 8];
					end
				end
			end
		end
	end

endmodule

// File: logic/lsu_request_ctrl.sv
`timescale 1ns/1ps

module lsu_request_ctrl import lsu_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              req_valid,
	output logic              req_ready,
	input  mem_op_e           req_op,
	input  logic [data_w-1:0] req_base,
	input  logic [data_w-1:0] req_imm,
	input  logic [data_w-1:0] req_wdata,
	output logic              resp_valid,
	input  logic              resp_ready,
	output logic [data_w-1:0] resp_data,
	output resp_e             resp_status,
	output logic              ld_start,
	output logic              st_start,
	output logic [addr_w-1:0] acc_addr,
	output mem_op_e           acc_op,
	output logic [data_w-1:0] acc_wdata,
	input  logic              ld_done,
	input  logic              st_done,
	input  logic [data_w-1:0] ld_data,
	input  axi_resp_e         ld_resp,
	input  axi_resp_e         st_resp
);

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_respond
	} state_e;

	state_e            state;
	logic [addr_w-1:0] eff_addr;
	logic              misaligned;
	logic              is_store;
	logic              req_fire;

	assign req_ready  = (state == st_idle);
	assign resp_valid = (state == st_respond);
	assign req_fire   = req_valid && req_ready;

	assign eff_addr = req_base + req_imm;
	assign is_store = req_op inside {op_sb, op_sh, op_sw};

	always_comb begin
		case (req_op)
			op_lh, op_lhu, op_sh: misaligned = eff_addr[0];
			op_lw, op_sw:         misaligned = |eff_addr[off_w-1:0];
			default:              misaligned = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state    <= st_idle;
			ld_start <= 1'b0;
			st_start <= 1'b0;
		end else begin
			ld_start <= 1'b0;
			st_start <= 1'b0;
			case (state)
				st_idle: begin
					if (req_fire) begin
						if (misaligned) begin
							state <= st_respond;
						end else begin
							state    <= st_busy;
							ld_start <= !is_store;
							st_start <= is_store;
						end
					end
				end
				st_busy: begin
					if (ld_done || st_done) begin
						state <= st_respond;
					end
				end
				default: begin
					if (resp_ready) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// access payload and the held response.
	always_ff @(posedge clock) begin
		if (req_fire) begin
			acc_addr  <= eff_addr;
			acc_op    <= req_op;
			acc_wdata <= req_wdata;
			if (misaligned) begin
				resp_data   <= '0;
				resp_status <= resp_misaligned;
			end
		end
		if (state == st_busy && ld_done) begin
			resp_data   <= ld_data;
			resp_status <= (ld_resp == axi_slverr) ? resp_bus_error : resp_okay;
		end else if (state == st_busy && st_done) begin
			resp_data   <= '0;
			resp_status <= (st_resp == axi_slverr) ? resp_bus_error : resp_okay;
		end
	end

endmodule

// File: logic/lsu_store_unit.sv
`timescale 1ns/1ps

module lsu_store_unit import lsu_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              start,
	input  logic [addr_w-1:0] addr,
	input  mem_op_e           op,
	input  logic [data_w-1:0] wdata,
	output logic              done,
	output axi_resp_e         resp,
	axi_lite_if.master        bus
);

	logic              aw_pend;
	logic              w_pend;
	logic [addr_w-1:0] aw_addr_q;
	logic [data_w-1:0] w_data_q;
	logic [strb_w-1:0] w_strb_q;
	logic [strb_w-1:0] size_mask;
	logic              b_fire;

	assign bus.aw_valid = aw_pend;
	assign bus.aw_addr  = aw_addr_q;
	assign bus.w_valid  = w_pend;
	assign bus.w_data   = w_data_q;
	assign bus.w_strb   = w_strb_q;
	assign bus.b_ready  = 1'b1;

	assign b_fire = bus.b_valid && bus.b_ready;

	// byte enables for the access size before the lane shift.
	always_comb begin
		case (op)
			op_sb:   size_mask = 4'b0001;
			op_sh:   size_mask = 4'b0011;
			default: size_mask = 4'b1111;
		endcase
	end

	// aw and w complete independently of each other.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
			done    <= 1'b0;
		end else begin
			if (start) begin
				aw_pend <= 1'b1;
			end else if (bus.aw_ready) begin
				aw_pend <= 1'b0;
			end
			if (start) begin
				w_pend <= 1'b1;
			end else if (bus.w_ready) begin
				w_pend <= 1'b0;
			end
			done <= b_fire;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			aw_addr_q <= {addr[addr_w-1:off_w], {off_w{1'b0}}};
			w_data_q  <= wdata << {addr[off_w-1:0], 3'b000};
			w_strb_q  <= size_mask << addr[off_w-1:0];
		end
		if (b_fire) begin
			resp <= bus.b_resp;
		end
	end

endmodule

// File: logic/lsu_load_unit.sv
`timescale 1ns/1ps

module lsu_load_unit import lsu_pkg::*; (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              start,
	input  logic [addr_w-1:0] addr,
	input  mem_op_e           op,
	output logic              done,
	output logic [data_w-1:0] data,
	output axi_resp_e         resp,
	axi_lite_if.master        bus
);

	logic              ar_pend;
	logic [addr_w-1:0] ar_addr_q;
	logic [off_w-1:0]  offset_q;
	mem_op_e           op_q;
	logic [data_w-1:0] shifted;
	logic [data_w-1:0] extended;
	logic              r_fire;

	assign bus.ar_valid = ar_pend;
	assign bus.ar_addr  = ar_addr_q;
	assign bus.r_ready  = 1'b1;

	assign r_fire = bus.r_valid && bus.r_ready;

	// move the addressed lane down to bit 0.
	assign shifted = bus.r_data >> {offset_q, 3'b000};

	always_comb begin
		case (op_q)
			op_lb:   extended = {{(data_w - 8){shifted[7]}}, shifted[7:0]};
			op_lh:   extended = {{(data_w - 16){shifted[15]}}, shifted[15:0]};
			op_lbu:  extended = {{(data_w - 8){1'b0}}, shifted[7:0]};
			op_lhu:  extended = {{(data_w - 16){1'b0}}, shifted[15:0]};
			default: extended = shifted;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			ar_pend <= 1'b0;
			done    <= 1'b0;
		end else begin
			if (start) begin
				ar_pend <= 1'b1;
			end else if (bus.ar_ready) begin
				ar_pend <= 1'b0;
			end
			done <= r_fire;
		end
	end

	always_ff @(posedge clock) begin
		if (start) begin
			ar_addr_q <= {addr[addr_w-1:off_w], {off_w{1'b0}}};
			offset_q  <= addr[off_w-1:0];
			op_q      <= op;
		end
		if (r_fire) begin
			data <= extended;
			resp <= bus.r_resp;
		end
	end

endmodule

// File: logic/axi_lite_if.sv
`timescale 1ns/1ps

interface axi_lite_if import lsu_pkg::*; (
	input logic clock
);

	logic [addr_w-1:0] ar_addr;
	logic              ar_valid;
	logic              ar_ready;

	logic [data_w-1:0] r_data;
	axi_resp_e         r_resp;
	logic              r_valid;
	logic              r_ready;

	logic [addr_w-1:0] aw_addr;
	logic              aw_valid;
	logic              aw_ready;

	logic [data_w-1:0] w_data;
	logic [strb_w-1:0] w_strb;
	logic              w_valid;
	logic              w_ready;

	axi_resp_e         b_resp;
	logic              b_valid;
	logic              b_ready;

	modport master (
		input  clock,
		output ar_addr, ar_valid, input ar_ready,
		input  r_data, r_resp, r_valid, output r_ready,
		output aw_addr, aw_valid, input aw_ready,
		output w_data, w_strb, w_valid, input w_ready,
		input  b_resp, b_valid, output b_ready
	);

	modport slave (
		input  clock,
		input  ar_addr, ar_valid, output ar_ready,
		output r_data, r_resp, r_valid, input r_ready,
		input  aw_addr, aw_valid, output aw_ready,
		input  w_data, w_strb, w_valid, output w_ready,
		output b_resp, b_valid, input b_ready
	);

endinterface

// File: logic/lsu_pkg.sv
package lsu_pkg;

	localparam int addr_w    = 32;
	localparam int data_w    = 32;
	localparam int strb_w    = data_w / 8;
	localparam int off_w     = 2;
	localparam int mem_words = 1024;
	localparam int mem_idx_w = 10;

	// bit 3 marks a store, bit 2 an unsigned load, bits 1:0 the size.
	typedef enum logic [3:0] {
		op_lb  = 4'b0000,
		op_lh  = 4'b0001,
		op_lw  = 4'b0010,
		op_lbu = 4'b0100,
		op_lhu = 4'b0101,
		op_sb  = 4'b1000,
		op_sh  = 4'b1001,
		op_sw  = 4'b1010
	} mem_op_e;

	// AXI response codes as seen on the r and b channels.
	typedef enum logic [1:0] {
		axi_okay   = 2'b00,
		axi_slverr = 2'b10
	} axi_resp_e;

	// status returned to the core.
	typedef enum logic [1:0] {
		resp_okay       = 2'b00,
		resp_misaligned = 2'b01,
		resp_bus_error  = 2'b10
	} resp_e;

endpackage
